//--- hdl/isa_pkg.sv
package isa_pkg;

    ////////////////////////////////////////////////////////////
    // datapath widths
    ////////////////////////////////////////////////////////////

    localparam int DATA_W = 32;
    localparam int FUNC_W = 6;

    ////////////////////////////////////////////////////////////
    // special-opcode func codes handled by the mul/div unit
    ////////////////////////////////////////////////////////////

    localparam logic [FUNC_W-1:0] FUNC_MULT = 6'b011000;
    localparam logic [FUNC_W-1:0] FUNC_DIV  = 6'b011010;

endpackage

//--- hdl/mdu_pkg.sv
package mdu_pkg;

    // double-length datapath for product and remainder/quotient
    localparam int PROD_W = 64;

    localparam int DIV_STEPS = 32;
    localparam int DIV_CNT_W = $clog2(DIV_STEPS + 1);

    // sequencer states
    typedef enum logic [1:0] {
        ST_READY = 2'b00,
        ST_WORK  = 2'b01,
        ST_DONE  = 2'b11
    } mdu_state_t;

endpackage

//--- hdl/muldiv_sequencer.sv
`timescale 1ns/10ps

module muldiv_sequencer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [isa_pkg::FUNC_W-1:0] func,
    input  logic                       reg_stall,
    input  logic                       mul_done,
    input  logic                       div_done,
    output logic                       start_mul,
    output logic                       start_div,
    output logic                       alu_stall
);
    import isa_pkg::*;
    import mdu_pkg::*;

    logic       is_mul;
    logic       is_div;
    logic       unit_op;
    mdu_state_t state;

    assign is_mul  = (func == FUNC_MULT);
    assign is_div  = (func == FUNC_DIV);
    assign unit_op = is_mul | is_div;

    // stall from the first cycle of the op until the result lands
    assign alu_stall = unit_op & (state != ST_DONE);

    assign start_mul = is_mul & (state == ST_READY);
    assign start_div = is_div & (state == ST_READY);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_READY;
        end else begin
            unique case (state)
                ST_READY: begin
                    if (unit_op) begin
                        state <= ST_WORK;
                    end
                end
                ST_WORK: begin
                    if (mul_done | div_done) begin
                        state <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    // hold while the rest of the pipe is stalled
                    if (!reg_stall) begin
                        state <= ST_READY;
                    end
                end
                default: state <= ST_READY;
            endcase
        end
    end

endmodule

//--- hdl/shift_add_multiplier.sv
`timescale 1ns/10ps

module shift_add_multiplier (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  logic                       sign,
    input  logic [isa_pkg::DATA_W-1:0] source_a,
    input  logic [isa_pkg::DATA_W-1:0] source_b,
    output logic                       done,
    output logic [isa_pkg::DATA_W-1:0] result_hi,
    output logic [isa_pkg::DATA_W-1:0] result_lo
);
    import isa_pkg::*;
    import mdu_pkg::*;

    logic              busy;
    logic [PROD_W-1:0] acc;
    logic [PROD_W-1:0] mcand;
    logic [PROD_W-1:0] mplier;

    // finished once no multiplier bits are left
    assign done      = busy & (mplier == '0);
    assign result_hi = acc[PROD_W-1:DATA_W];
    assign result_lo = acc[DATA_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc <= '0;
            if (sign) begin
                mplier <= {{(PROD_W-DATA_W){source_a[DATA_W-1]}}, source_a};
                mcand  <= {{(PROD_W-DATA_W){source_b[DATA_W-1]}}, source_b};
            end else begin
                mplier <= {{(PROD_W-DATA_W){1'b0}}, source_a};
                mcand  <= {{(PROD_W-DATA_W){1'b0}}, source_b};
            end
        end else if (busy && mplier != '0) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mplier <= {1'b0, mplier[PROD_W-1:1]};
            mcand  <= {mcand[PROD_W-2:0], 1'b0};
        end
    end

endmodule

//--- hdl/restoring_divider.sv
`timescale 1ns/10ps

module restoring_divider (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  logic                       sign,
    input  logic [isa_pkg::DATA_W-1:0] source_a,
    input  logic [isa_pkg::DATA_W-1:0] source_b,
    output logic                       done,
    output logic [isa_pkg::DATA_W-1:0] result_hi,
    output logic [isa_pkg::DATA_W-1:0] result_lo
);
    import isa_pkg::*;
    import mdu_pkg::*;

    logic                 busy;
    logic [DIV_CNT_W-1:0] count;
    // upper half remainder, lower half dividend bits turning into quotient
    logic [PROD_W-1:0]    work;
    logic [DATA_W-1:0]    divisor;
    logic                 neg_a;
    logic                 neg_b;
    logic [DATA_W-1:0]    abs_a;
    logic [DATA_W-1:0]    abs_b;
    logic [DATA_W:0]      rem_shift;
    logic [DATA_W:0]      rem_diff;
    logic [DATA_W-1:0]    quot;
    logic [DATA_W-1:0]    rem;

    assign abs_a = (sign && source_a[DATA_W-1]) ? -source_a : source_a;
    assign abs_b = (sign && source_b[DATA_W-1]) ? -source_b : source_b;

    // 33 bits so a large remainder is not lost on the shift
    assign rem_shift = work[PROD_W-1:DATA_W-1];
    assign rem_diff  = rem_shift - {1'b0, divisor};

    ////////////////////////////////////////////////////////////
    // sign fix in the final cycle
    ////////////////////////////////////////////////////////////

    assign quot      = work[DATA_W-1:0];
    assign rem       = work[PROD_W-1:DATA_W];
    assign done      = busy & (count == '0);
    assign result_lo = (neg_a ^ neg_b) ? -quot : quot;
    assign result_hi = neg_a ? -rem : rem;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy  <= 1'b1;
            count <= DIV_CNT_W'(DIV_STEPS);
        end else if (done) begin
            busy <= 1'b0;
        end else if (busy) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            work    <= {{(PROD_W-DATA_W){1'b0}}, abs_a};
            divisor <= abs_b;
            neg_a   <= sign & source_a[DATA_W-1];
            neg_b   <= sign & source_b[DATA_W-1];
        end else if (busy && count != '0) begin
            // no borrow means the divisor fits
            if (!rem_diff[DATA_W]) begin
                work <= {rem_diff[DATA_W-1:0], work[DATA_W-2:0], 1'b1};
            end else begin
                work <= {work[PROD_W-2:0], 1'b0};
            end
        end
    end

endmodule

//--- hdl/hilo_regs.sv
`timescale 1ns/10ps

module hilo_regs (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       hi_write,
    input  logic [isa_pkg::DATA_W-1:0] hi_write_data,
    input  logic                       lo_write,
    input  logic [isa_pkg::DATA_W-1:0] lo_write_data,
    input  logic                       mul_done,
    input  logic [isa_pkg::DATA_W-1:0] mul_hi,
    input  logic [isa_pkg::DATA_W-1:0] mul_lo,
    input  logic                       div_done,
    input  logic [isa_pkg::DATA_W-1:0] div_hi,
    input  logic [isa_pkg::DATA_W-1:0] div_lo,
    output logic [isa_pkg::DATA_W-1:0] hi,
    output logic [isa_pkg::DATA_W-1:0] lo
);

    // engine results win over mthi/mtlo
    always_ff @(posedge clk) begin
        if (rst) begin
            hi <= '0;
            lo <= '0;
        end else if (mul_done) begin
            hi <= mul_hi;
            lo <= mul_lo;
        end else if (div_done) begin
            hi <= div_hi;
            lo <= div_lo;
        end else begin
            if (hi_write) begin
                hi <= hi_write_data;
            end
            if (lo_write) begin
                lo <= lo_write_data;
            end
        end
    end

endmodule

//--- hdl/muldiv_unit.sv
`timescale 1ns/10ps

module muldiv_unit (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       reg_stall,
    output logic                       alu_stall,
    input  logic                       sign,
    input  logic [isa_pkg::FUNC_W-1:0] func,
    input  logic [isa_pkg::DATA_W-1:0] source_a,
    input  logic [isa_pkg::DATA_W-1:0] source_b,
    output logic [isa_pkg::DATA_W-1:0] hi,
    output logic [isa_pkg::DATA_W-1:0] lo,
    input  logic                       hi_write,
    input  logic                       lo_write,
    input  logic [isa_pkg::DATA_W-1:0] hi_write_data,
    input  logic [isa_pkg::DATA_W-1:0] lo_write_data
);
    import isa_pkg::*;

    logic              start_mul;
    logic              start_div;
    logic              mul_done;
    logic              div_done;
    logic [DATA_W-1:0] mul_hi;
    logic [DATA_W-1:0] mul_lo;
    logic [DATA_W-1:0] div_hi;
    logic [DATA_W-1:0] div_lo;

    muldiv_sequencer u_seq (
        .clk       (clk),
        .rst       (rst),
        .func      (func),
        .reg_stall (reg_stall),
        .mul_done  (mul_done),
        .div_done  (div_done),
        .start_mul (start_mul),
        .start_div (start_div),
        .alu_stall (alu_stall)
    );

    shift_add_multiplier u_mul (
        .clk       (clk),
        .rst       (rst),
        .start     (start_mul),
        .sign      (sign),
        .source_a  (source_a),
        .source_b  (source_b),
        .done      (mul_done),
        .result_hi (mul_hi),
        .result_lo (mul_lo)
    );

    restoring_divider u_div (
        .clk       (clk),
        .rst       (rst),
        .start     (start_div),
        .sign      (sign),
        .source_a  (source_a),
        .source_b  (source_b),
        .done      (div_done),
        .result_hi (div_hi),
        .result_lo (div_lo)
    );

    hilo_regs u_hilo (
        .clk           (clk),
        .rst           (rst),
        .hi_write      (hi_write),
        .hi_write_data (hi_write_data),
        .lo_write      (lo_write),
        .lo_write_data (lo_write_data),
        .mul_done      (mul_done),
        .mul_hi        (mul_hi),
        .mul_lo        (mul_lo),
        .div_done      (div_done),
        .div_hi        (div_hi),
        .div_lo        (div_lo),
        .hi            (hi),
        .lo            (lo)
    );

endmodule

//--- test/muldiv_checker.sv
`timescale 1ns/10ps

module muldiv_checker (
    input logic                       clk,
    input logic                       rst,
    input logic [isa_pkg::FUNC_W-1:0] func,
    input logic                       reg_stall,
    input logic                       alu_stall,
    input logic                       mul_done,
    input logic                       div_done,
    input logic                       hi_write,
    input logic                       lo_write,
    input logic [isa_pkg::DATA_W-1:0] hi,
    input logic [isa_pkg::DATA_W-1:0] lo
);
    import isa_pkg::*;
    import mdu_pkg::*;

    int   fails = 0;
    int   div_run;
    logic unit_op;
    logic div_stall;

    assign unit_op   = (func == FUNC_MULT) || (func == FUNC_DIV);
    assign div_stall = alu_stall && (func == FUNC_DIV);

    // divide stall cycles seen before the current one
    always @(posedge clk) begin
        if (rst || !div_stall) begin
            div_run <= 0;
        end else begin
            div_run <= div_run + 1;
        end
    end

    // the stall ends only right after an engine result was written
    stall_ends_on_done: assert property (@(posedge clk) disable iff (rst)
        (unit_op && $fell(alu_stall)) |-> $past(mul_done || div_done))
    else begin
        fails++;
        $error("alu_stall fell without an engine result");
    end

    hilo_hold: assert property (@(posedge clk) disable iff (rst)
        (!alu_stall && reg_stall && !hi_write && !lo_write) |=> ($stable(hi) && $stable(lo)))
    else begin
        fails++;
        $error("hi or lo changed while the pipeline was stalled");
    end

    // 1 start, DIV_STEPS steps, 1 sign fix
    div_stall_limit: assert property (@(posedge clk) disable iff (rst)
        div_stall |-> (div_run < DIV_STEPS + 2))
    else begin
        fails++;
        $error("divide stall longer than %0d cycles", DIV_STEPS + 2);
    end

endmodule

bind muldiv_unit muldiv_checker u_checker (
    .clk       (clk),
    .rst       (rst),
    .func      (func),
    .reg_stall (reg_stall),
    .alu_stall (alu_stall),
    .mul_done  (mul_done),
    .div_done  (div_done),
    .hi_write  (hi_write),
    .lo_write  (lo_write),
    .hi        (hi),
    .lo        (lo)
);

//--- test/muldiv_monitor.sv
`timescale 1ns/10ps

module muldiv_monitor (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [isa_pkg::FUNC_W-1:0] func,
    input  logic                       sign,
    input  logic [isa_pkg::DATA_W-1:0] source_a,
    input  logic                       alu_stall,
    input  logic                       hi_write,
    input  logic                       lo_write,
    input  logic [isa_pkg::DATA_W-1:0] hi,
    input  logic [isa_pkg::DATA_W-1:0] lo,
    input  logic [isa_pkg::DATA_W-1:0] exp_hi,
    input  logic [isa_pkg::DATA_W-1:0] exp_lo,
    output int                         errors
);
    import isa_pkg::*;

    int   checks;
    int   stall_cycles;
    int   want_cycles;
    logic after_rst;
    logic wrote;

    // 2 cycles plus the significant bits of the extended multiplier
    function automatic int mul_latency(input logic [DATA_W-1:0] a, input logic s);
        int bits;
        int i;
        bits = 0;
        for (i = 0; i < DATA_W; i++) begin
            if (a[i]) begin
                bits = i + 1;
            end
        end
        if (s && a[DATA_W-1]) begin
            bits = 2 * DATA_W;
        end
        return bits + 2;
    endfunction

    task automatic compare(input string what);
        checks++;
        if (hi !== exp_hi || lo !== exp_lo) begin
            errors++;
            $display("ERR @%0t: %s hi:lo %h:%h, expected %h:%h",
                     $time, what, hi, lo, exp_hi, exp_lo);
        end
    endtask

    initial begin
        errors = 0;
        checks = 0;
        stall_cycles = 0;
    end

    always @(posedge clk) begin
        if (rst) begin
            after_rst <= 1'b1;
            wrote     <= 1'b0;
            stall_cycles = 0;
        end else begin
            after_rst <= 1'b0;
            wrote     <= hi_write | lo_write;
            if (after_rst) begin
                checks++;
                if (hi !== '0 || lo !== '0) begin
                    errors++;
                    $display("ERR @%0t: hi:lo %h:%h after reset, expected zero", $time, hi, lo);
                end
            end
            if (wrote) begin
                compare("direct write");
            end
            if (func == FUNC_MULT || func == FUNC_DIV) begin
                if (alu_stall) begin
                    stall_cycles++;
                end else begin
                    compare((func == FUNC_DIV) ? "div" : "mult");
                    // latency only on the first done cycle
                    if (stall_cycles != 0) begin
                        want_cycles = (func == FUNC_DIV) ? 34 : mul_latency(source_a, sign);
                        checks++;
                        if (stall_cycles != want_cycles) begin
                            errors++;
                            $display("ERR @%0t: stall of %0d cycles, expected %0d",
                                     $time, stall_cycles, want_cycles);
                        end
                    end
                    stall_cycles = 0;
                end
            end
        end
    end

endmodule

//--- test/tb_muldiv.sv
`timescale 1ns/10ps

module tb_muldiv;
    import isa_pkg::*;

    localparam int                STALL_TIMEOUT = 100;
    localparam logic [FUNC_W-1:0] FUNC_MTHI     = 6'h11;
    localparam logic [FUNC_W-1:0] FUNC_MTLO     = 6'h13;

    logic              clk;
    logic              rst;
    logic              reg_stall;
    logic              alu_stall;
    logic              sign;
    logic [FUNC_W-1:0] func;
    logic [DATA_W-1:0] source_a;
    logic [DATA_W-1:0] source_b;
    logic [DATA_W-1:0] hi;
    logic [DATA_W-1:0] lo;
    logic              hi_write;
    logic              lo_write;
    logic [DATA_W-1:0] hi_write_data;
    logic [DATA_W-1:0] lo_write_data;
    logic [DATA_W-1:0] exp_hi;
    logic [DATA_W-1:0] exp_lo;
    logic [31:0]       rand_state;
    int                mon_errors;

    muldiv_unit DUT (.*);

    muldiv_monitor u_mon (
        .errors (mon_errors),
        .*
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    ////////////////////////////////////////////////////////////
    // one pattern line per task call
    ////////////////////////////////////////////////////////////

    task automatic direct_write(input logic [FUNC_W-1:0] f, input logic [DATA_W-1:0] a,
                                input logic [DATA_W-1:0] b);
        func          = f;
        hi_write      = (f == FUNC_MTHI);
        lo_write      = (f == FUNC_MTLO);
        hi_write_data = a;
        lo_write_data = b;
        @(negedge clk);
        hi_write = 1'b0;
        lo_write = 1'b0;
        func     = '0;
        @(negedge clk);
    endtask

    task automatic run_op(input logic [FUNC_W-1:0] f, input logic s,
                          input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
                          output logic timed_out);
        int n;
        int hold;
        func      = f;
        sign      = s;
        source_a  = a;
        source_b  = b;
        reg_stall = 1'b0;
        timed_out = 1'b0;
        n = 0;
        @(negedge clk);
        while (alu_stall && n < STALL_TIMEOUT) begin
            n++;
            @(negedge clk);
        end
        if (alu_stall) begin
            $display("timeout: alu_stall still high after %0d cycles", STALL_TIMEOUT);
            timed_out = 1'b1;
        end else begin
            // back-pressure in the done state
            rand_state = next_random(rand_state);
            hold = int'(rand_state[17:16]);
            reg_stall = (hold != 0);
            repeat (hold) @(negedge clk);
            reg_stall = 1'b0;
            @(negedge clk);
        end
        func = '0;
    endtask

    initial begin
        int                fd;
        string             line;
        logic              aborted;
        logic [FUNC_W-1:0] f;
        logic              sgn;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] eh;
        logic [DATA_W-1:0] el;
        clk = 1'b0;
        rst = 1'b1;
        reg_stall = 1'b0;
        func = '0;
        sign = 1'b0;
        source_a = '0;
        source_b = '0;
        hi_write = 1'b0;
        lo_write = 1'b0;
        hi_write_data = '0;
        lo_write_data = '0;
        exp_hi = '0;
        exp_lo = '0;
        rand_state = 32'hf649;
        aborted = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        fd = $fopen("test/muldiv_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open test/muldiv_patterns.txt");
            aborted = 1'b1;
        end
        while (!aborted && $fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            void'($sscanf(line, "%h %h %h %h %h %h", f, sgn, a, b, eh, el));
            exp_hi = eh;
            exp_lo = el;
            if (f == FUNC_MULT || f == FUNC_DIV) begin
                run_op(f, sgn, a, b, aborted);
            end else begin
                direct_write(f, a, b);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        @(negedge clk);
        $display("checks %0d, compare errors %0d, assertion failures %0d",
                 u_mon.checks, mon_errors, DUT.u_checker.fails);
        if (aborted || mon_errors != 0 || DUT.u_checker.fails != 0) begin
            $display("FAIL: see errors above");
        end else begin
            $display("PASS: all tests");
        end
        $finish;
    end

endmodule

//--- sources.f
hdl/isa_pkg.sv
hdl/mdu_pkg.sv
hdl/muldiv_sequencer.sv
hdl/shift_add_multiplier.sv
hdl/restoring_divider.sv
hdl/hilo_regs.sv
hdl/muldiv_unit.sv
test/muldiv_checker.sv
test/muldiv_monitor.sv
test/tb_muldiv.sv

//--- Makefile
# Verilator build and run for the multiply/divide unit

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_muldiv \
		-f sources.f -Mdir obj_dir -o sim_muldiv

# the log decides pass or fail
run: compile
	./obj_dir/sim_muldiv +verilator+error+limit+1000 | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

//--- test/muldiv_patterns.txt
# func sign a b hi lo, all hex; func 11 writes hi from a, 13 writes lo from b
# 18 is mult, 1a is div; hi:lo is the product, or remainder:quotient
11 0 12345678 00000000 12345678 00000000
13 0 00000000 9abcdef0 12345678 9abcdef0
18 0 00000003 00000005 00000000 0000000f
18 0 ffffffff ffffffff fffffffe 00000001
18 0 80000000 00000002 00000001 00000000
18 0 12345678 00010000 00001234 56780000
18 1 00000000 7fffffff 00000000 00000000
18 1 ffffffff 00000007 ffffffff fffffff9
18 1 fffffffe fffffffd 00000000 00000006
18 1 80000000 80000000 40000000 00000000
18 1 00000064 ffffff9c ffffffff ffffd8f0
1a 0 00000064 00000007 00000002 0000000e
1a 0 ffffffff 00000010 0000000f 0fffffff
1a 0 00000005 00000009 00000005 00000000
1a 0 80000000 ffffffff 80000000 00000000
1a 1 ffffff9c 00000007 fffffffe fffffff2
1a 1 00000064 fffffff9 00000002 fffffff2
1a 1 ffffff9c fffffff9 fffffffe 0000000e
1a 1 80000000 00000002 00000000 c0000000
